// File: Makefile
# Verilator flow for the I/O peripheral

OBJ_DIR := obj_dir
LOG     := sim.log

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing -Wall -f vlog.f --top-module io_top
	verilator --lint-only --timing -f vlog.f --top-module io_tb

sim:
	verilator --binary --timing --assert -Wno-fatal -f vlog.f --top-module io_tb \
		-Mdir $(OBJ_DIR) -o io_tb_sim
	-./$(OBJ_DIR)/io_tb_sim 2>&1 | tee $(LOG)
	@if grep -q "STATUS: FAIL" $(LOG); then echo "Simulation failed"; exit 1; fi
	@if ! grep -q "STATUS: PASS" $(LOG); then echo "Simulation incomplete"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: source/io_gpio.sv
`timescale 1ns/10ps
`default_nettype none

module io_gpio #(
    parameter int SYNC_STAGES = 2
) (
    input  logic               clk,
    input  logic               rst,
    input  io_pkg::gpio_cfg_t  gpio_cfg,
    input  io_pkg::timer_cfg_t timer_cfg,
    input  io_pkg::timer_out_t tout,
    input  logic [7:0]         pins_in,
    output logic [7:0]         pins_out,
    output logic [7:0]         pins_oe,
    output logic [7:0]         pins_sync
);

    logic [SYNC_STAGES-1:0][7:0] sync_q;

    //****************************************
    // Output drive
    //****************************************
    assign pins_oe = gpio_cfg.dir;

    // Timer outputs may take over the two top pins
    assign pins_out[5:0] = gpio_cfg.port[5:0];
    assign pins_out[6]   = timer_cfg.ctrl.pin6_sel ? tout.out0 : gpio_cfg.port[6];
    assign pins_out[7]   = timer_cfg.ctrl.pin7_sel ? tout.out1 : gpio_cfg.port[7];

    //****************************************
    // Input synchronizer
    //****************************************
    always_ff @(posedge clk) begin
        if (rst) begin
            sync_q <= '0;
        end else begin
            sync_q[0] <= pins_in;
            for (int i = 1; i < SYNC_STAGES; i++) begin
                sync_q[i] <= sync_q[i-1];   // Shift toward the top stage
            end
        end
    end

    assign pins_sync = sync_q[SYNC_STAGES-1];

endmodule

`default_nettype wire

// File: source/io_pkg.sv
`default_nettype none

package io_pkg;

    //****************************************
    // Memory map
    //****************************************
    typedef enum logic [7:0] {
        ADDR_DIR      = 8'h00,
        ADDR_PORT     = 8'h01,
        ADDR_PINS     = 8'h02,  // Read only
        ADDR_SCALE_LO = 8'h03,
        ADDR_SCALE_HI = 8'h04,
        ADDR_CTRL     = 8'h05,
        ADDR_CMPR0    = 8'h06,
        ADDR_CMPR1    = 8'h07,
        ADDR_COUNT    = 8'h08   // Read only
    } io_addr_e;

    // Two bytes of scale in the map
    parameter int SCALE_W = 16;

    //****************************************
    // Timer configuration
    //****************************************
    typedef enum logic [1:0] {
        MODE_IDLE = 2'd0,
        MODE_CTC  = 2'd1,
        MODE_PWM  = 2'd2,
        MODE_RSVD = 2'd3        // Counter frozen
    } timer_mode_e;

    // Bit 0..1 mode, bit 2 pin 6 select, bit 3 pin 7 select
    typedef struct packed {
        logic [3:0]  rsvd;
        logic        pin7_sel;
        logic        pin6_sel;
        timer_mode_e mode;
    } timer_ctrl_t;

    typedef struct packed {
        timer_ctrl_t ctrl;
        logic [7:0]  cmpr0;
        logic [7:0]  cmpr1;
    } timer_cfg_t;

    typedef struct packed {
        logic [7:0] dir;        // 1 = output
        logic [7:0] port;
    } gpio_cfg_t;

    typedef struct packed {
        logic out1;
        logic out0;
    } timer_out_t;

endpackage

`default_nettype wire

// File: source/io_prescaler.sv
`timescale 1ns/10ps
`default_nettype none

module io_prescaler (
    input  logic                       clk,
    input  logic                       rst,
    input  logic [io_pkg::SCALE_W-1:0] scale,
    output logic                       tick
);
    import io_pkg::*;

    logic [SCALE_W-1:0] cnt;

    // Match on equality only, so a lowered scale wraps through zero
    always_ff @(posedge clk) begin
        if (rst) begin
            cnt  <= '0;
            tick <= 1'b0;
        end else if (cnt == scale) begin
            cnt  <= '0;
            tick <= 1'b1;
        end else begin
            cnt  <= cnt + 1'b1;
            tick <= 1'b0;
        end
    end

    a_tick_single : assert property (
        @(posedge clk) disable iff (rst)
        (scale != '0) && tick |=> !tick
    ) else $error("io_prescaler: back to back ticks with nonzero scale");

endmodule

`default_nettype wire

// File: source/io_regs.sv
`timescale 1ns/10ps
`default_nettype none

module io_regs #(
    parameter int SYNC_STAGES = 2
) (
    input  logic                       clk,
    input  logic                       rst,
    input  io_pkg::io_addr_e           addr,
    input  logic [7:0]                 wdata,
    input  logic                       w_en,
    input  logic                       r_en,
    output logic [7:0]                 rdata,
    input  logic [7:0]                 count,
    input  logic [7:0]                 pins_sync,
    output io_pkg::gpio_cfg_t          gpio_cfg,
    output io_pkg::timer_cfg_t         timer_cfg,
    output logic [io_pkg::SCALE_W-1:0] scale
);
    import io_pkg::*;

    // PINS reads trail the pads by SYNC_STAGES cycles plus the read cycle
    if (SYNC_STAGES < 1) begin : g_sync_check
        $error("io_regs: SYNC_STAGES must be at least 1");
    end

    //****************************************
    // Register writes
    //****************************************
    always_ff @(posedge clk) begin
        if (rst) begin
            gpio_cfg  <= '0;
            timer_cfg <= '0;
            scale     <= '0;
        end else if (w_en) begin
            case (addr)
                ADDR_DIR:      gpio_cfg.dir    <= wdata;
                ADDR_PORT:     gpio_cfg.port   <= wdata;
                ADDR_SCALE_LO: scale[7:0]      <= wdata;
                ADDR_SCALE_HI: scale[15:8]     <= wdata;
                ADDR_CTRL:     timer_cfg.ctrl  <= timer_ctrl_t'(wdata);
                ADDR_CMPR0:    timer_cfg.cmpr0 <= wdata;
                ADDR_CMPR1:    timer_cfg.cmpr1 <= wdata;
                // PINS and COUNT are read only
                default: begin
                end
            endcase
        end
    end

    //****************************************
    // Read mux, one cycle latency
    //****************************************
    always_ff @(posedge clk) begin
        if (rst) begin
            rdata <= '0;
        end else if (r_en) begin
            case (addr)
                ADDR_DIR:      rdata <= gpio_cfg.dir;
                ADDR_PORT:     rdata <= gpio_cfg.port;
                ADDR_PINS:     rdata <= pins_sync;
                ADDR_SCALE_LO: rdata <= scale[7:0];
                ADDR_SCALE_HI: rdata <= scale[15:8];
                ADDR_CTRL:     rdata <= timer_cfg.ctrl;
                ADDR_CMPR0:    rdata <= timer_cfg.cmpr0;
                ADDR_CMPR1:    rdata <= timer_cfg.cmpr1;
                ADDR_COUNT:    rdata <= count;
                default:       rdata <= rdata;  // Unmapped, keep last value
            endcase
        end
    end

    // Read data only moves on a read
    a_rdata_hold : assert property (
        @(posedge clk) disable iff (rst)
        !r_en |=> $stable(rdata)
    ) else $error("io_regs: rdata changed without a read");

endmodule

`default_nettype wire

// File: source/io_timer.sv
`timescale 1ns/10ps
`default_nettype none

module io_timer (
    input  logic               clk,
    input  logic               rst,
    input  logic               tick,
    input  io_pkg::timer_cfg_t timer_cfg,
    output logic [7:0]         count,
    output io_pkg::timer_out_t tout
);
    import io_pkg::*;

    logic match0;
    logic match1;

    assign match0 = (count == timer_cfg.cmpr0);
    assign match1 = (count == timer_cfg.cmpr1);

    //****************************************
    // Counter and compare outputs
    //****************************************
    always_ff @(posedge clk) begin
        if (rst) begin
            count <= '0;
            tout  <= '0;
        end else if (tick) begin
            case (timer_cfg.ctrl.mode)
                MODE_IDLE: begin
                    count <= '0;
                    tout  <= '0;
                end
                MODE_CTC: begin
                    if (match0) begin
                        count     <= '0;
                        tout.out0 <= ~tout.out0;    // Square wave on out0
                    end else begin
                        count <= count + 1'b1;
                    end
                end
                MODE_PWM: begin
                    // Period of 256 ticks, wraps naturally
                    count <= count + 1'b1;
                    if (count == 8'hff) begin
                        tout.out0 <= 1'b1;          // Both outputs rise at zero
                        tout.out1 <= 1'b1;
                    end else begin
                        if (match0) begin
                            tout.out0 <= 1'b0;
                        end
                        if (match1) begin
                            tout.out1 <= 1'b0;
                        end
                    end
                end
                default: begin
                    // Reserved mode holds everything
                    count <= count;
                    tout  <= tout;
                end
            endcase
        end
    end

    a_idle_clear : assert property (
        @(posedge clk) disable iff (rst)
        tick && (timer_cfg.ctrl.mode == MODE_IDLE) |=> (count == '0)
    ) else $error("io_timer: counter not cleared in idle mode");

endmodule

`default_nettype wire

// File: source/io_top.sv
`timescale 1ns/10ps
`default_nettype none

module io_top #(
    parameter int SYNC_STAGES = 2
) (
    input  logic       clk,
    input  logic       rst,
    input  logic [7:0] addr,
    input  logic [7:0] wdata,
    input  logic       w_en,
    input  logic       r_en,
    output logic [7:0] rdata,
    input  logic [7:0] pins_in,
    output logic [7:0] pins_out,
    output logic [7:0] pins_oe
);
    import io_pkg::*;

    gpio_cfg_t          gpio_cfg;
    timer_cfg_t         timer_cfg;
    logic [SCALE_W-1:0] scale;
    logic               tick;
    timer_out_t         tout;
    logic [7:0]         count;
    logic [7:0]         pins_sync;

    // Register bank and bus decoder
    io_regs #(
        .SYNC_STAGES(SYNC_STAGES)
    ) i_io_regs (
        .clk       (clk),
        .rst       (rst),
        .addr      (io_addr_e'(addr)),
        .wdata     (wdata),
        .w_en      (w_en),
        .r_en      (r_en),
        .rdata     (rdata),
        .count     (count),
        .pins_sync (pins_sync),
        .gpio_cfg  (gpio_cfg),
        .timer_cfg (timer_cfg),
        .scale     (scale)
    );

    io_prescaler i_io_prescaler (
        .clk   (clk),
        .rst   (rst),
        .scale (scale),
        .tick  (tick)
    );

    io_timer i_io_timer (
        .clk       (clk),
        .rst       (rst),
        .tick      (tick),
        .timer_cfg (timer_cfg),
        .count     (count),
        .tout      (tout)
    );

    io_gpio #(
        .SYNC_STAGES(SYNC_STAGES)
    ) i_io_gpio (
        .clk       (clk),
        .rst       (rst),
        .gpio_cfg  (gpio_cfg),
        .timer_cfg (timer_cfg),
        .tout      (tout),
        .pins_in   (pins_in),
        .pins_out  (pins_out),
        .pins_oe   (pins_oe),
        .pins_sync (pins_sync)
    );

endmodule

`default_nettype wire

// File: tests/io_tb.sv
`timescale 1ns/10ps
`default_nettype none

module io_tb;
    import io_pkg::*;

    localparam int SYNC_STAGES = 2;
    localparam int WRAP_CYCLES = 1 << SCALE_W;  // Prescaler pass through zero

    logic       clk;
    logic       rst;
    logic [7:0] addr;
    logic [7:0] wdata;
    logic       w_en;
    logic       r_en;
    logic [7:0] rdata;
    logic [7:0] pins_in;
    logic [7:0] pins_out;
    logic [7:0] pins_oe;

    integer seed = 32'he37a_25aa;

    io_top #(
        .SYNC_STAGES(SYNC_STAGES)
    ) i_io_top (
        .clk      (clk),
        .rst      (rst),
        .addr     (addr),
        .wdata    (wdata),
        .w_en     (w_en),
        .r_en     (r_en),
        .rdata    (rdata),
        .pins_in  (pins_in),
        .pins_out (pins_out),
        .pins_oe  (pins_oe)
    );

    always #5 clk = ~clk;

    //****************************************
    // Bus and check helpers
    //****************************************
    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("STATUS: FAIL");
        $fatal(1, "Simulation stopped on first error");
    endtask

    task automatic check(input string name, input logic [31:0] actual,
                         input logic [31:0] expected);
        if (actual !== expected) begin
            abort_run($sformatf("CHECK FAILED at %0t: %s is 0x%0h, expected 0x%0h",
                                $time, name, actual, expected));
        end
    endtask

    // Called 1 ns after an edge, returns 1 ns after the write edge
    task automatic bus_write(input io_addr_e a, input logic [7:0] data);
        addr  = a;
        wdata = data;
        w_en  = 1'b1;
        @(posedge clk);
        #1;
        w_en  = 1'b0;
    endtask

    task automatic bus_read(input io_addr_e a, output logic [7:0] data);
        addr = a;
        r_en = 1'b1;
        @(posedge clk);
        #1;
        r_en = 1'b0;
        data = rdata;   // Registered at the edge just passed
    endtask

    // Counts edges until pins_out[bit_idx] leaves its current value
    task automatic wait_pin_toggle(input int bit_idx, input int limit, output int cycles);
        logic start;
        start  = pins_out[bit_idx];
        cycles = 0;
        while (pins_out[bit_idx] == start) begin
            if (cycles >= limit) begin
                abort_run($sformatf("Timeout: pin %0d did not toggle within %0d cycles",
                                    bit_idx, limit));
            end
            @(posedge clk);
            #1;
            cycles++;
        end
    endtask

    //****************************************
    // Directed tests
    //****************************************
    task automatic test_reset_state();
        logic [7:0] data;
        for (int a = 0; a <= 8; a++) begin
            bus_read(io_addr_e'(a), data);
            check($sformatf("rdata @0x%02h after reset", a), data, 0);
        end
        check("pins_oe after reset", pins_oe, 0);
    endtask

    task automatic test_readback();
        logic [7:0] wr [0:8];
        logic [7:0] data;
        for (int a = 0; a <= 8; a++) begin
            wr[a] = $random(seed);
        end
        wr[ADDR_CTRL] = wr[ADDR_CTRL] & 8'hfc;  // Mode stays idle
        for (int a = 0; a <= 8; a++) begin
            bus_write(io_addr_e'(a), wr[a]);    // PINS and COUNT should drop these
        end
        for (int a = 0; a <= 8; a++) begin
            bus_read(io_addr_e'(a), data);
            if (a == ADDR_PINS) begin
                check("PINS after write", data, pins_in);
            end else if (a == ADDR_COUNT) begin
                check("COUNT after write", data, 0);
            end else begin
                check($sformatf("readback @0x%02h", a), data, wr[a]);
            end
        end
    endtask

    task automatic test_gpio();
        logic [7:0] dir_val;
        logic [7:0] port_val;
        logic [7:0] data;
        dir_val  = $random(seed);
        port_val = $random(seed);
        bus_write(ADDR_CTRL, 8'h00);            // Timer selects off
        bus_write(ADDR_DIR, dir_val);
        bus_write(ADDR_PORT, port_val);
        check("pins_oe", pins_oe, dir_val);
        check("pins_out", pins_out, port_val);
        pins_in = $random(seed);
        repeat (SYNC_STAGES + 1) @(posedge clk);
        #1;
        bus_read(ADDR_PINS, data);
        check("PINS", data, pins_in);
    endtask

    task automatic test_ctc();
        timer_ctrl_t ctrl;
        int          scale_val;
        int          cmp_val;
        int          period;
        int          cycles;
        scale_val = 1 + ($random(seed) & 3);
        cmp_val   = 2 + ($random(seed) & 7);
        period    = (cmp_val + 1) * (scale_val + 1);
        ctrl          = '0;
        ctrl.mode     = MODE_CTC;
        ctrl.pin6_sel = 1'b1;
        bus_write(ADDR_CTRL, 8'h00);
        bus_write(ADDR_SCALE_LO, scale_val[7:0]);
        bus_write(ADDR_SCALE_HI, 8'h00);
        bus_write(ADDR_CMPR0, cmp_val[7:0]);
        bus_write(ADDR_CTRL, ctrl);
        wait_pin_toggle(6, WRAP_CYCLES + 2 * period, cycles);  // Lowered scale may wrap
        for (int i = 0; i < 3; i++) begin
            wait_pin_toggle(6, 2 * period, cycles);
            check($sformatf("CTC interval %0d", i), cycles, period);
        end
    endtask

    task automatic test_pwm();
        timer_ctrl_t ctrl;
        logic [7:0]  duty0;
        logic [7:0]  duty1;
        logic [7:0]  data;
        int          cycles;
        int          high0;
        int          high1;
        duty0 = $random(seed) & 8'hfe;
        duty1 = $random(seed) & 8'hfe;
        ctrl          = '0;
        ctrl.pin6_sel = 1'b1;
        ctrl.pin7_sel = 1'b1;
        bus_write(ADDR_CTRL, 8'h00);
        bus_write(ADDR_SCALE_LO, 8'h00);
        bus_write(ADDR_SCALE_HI, 8'h00);
        bus_write(ADDR_CMPR0, duty0);
        bus_write(ADDR_CMPR1, duty1);
        bus_write(ADDR_PORT, 8'hc0);            // Port high on 6 and 7, timer must win
        ctrl.mode = MODE_PWM;
        bus_write(ADDR_CTRL, ctrl);
        wait_pin_toggle(6, WRAP_CYCLES + 600, cycles);
        if (!pins_out[6]) begin
            wait_pin_toggle(6, 600, cycles);
        end
        high0 = 0;
        high1 = 0;
        for (int i = 0; i < 256; i++) begin
            high0 += pins_out[6];
            high1 += pins_out[7];
            @(posedge clk);
            #1;
        end
        check("PWM pin 6 high cycles", high0, duty0 + 1);
        check("PWM pin 7 high cycles", high1, duty1 + 1);
        ctrl.mode = MODE_IDLE;
        bus_write(ADDR_CTRL, ctrl);
        @(posedge clk);     // Scale 0 gives a tick here
        #1;
        check("pins_out[7:6] in idle", pins_out[7:6], 2'b00);
        bus_read(ADDR_COUNT, data);
        check("COUNT in idle", data, 0);
    endtask

    //****************************************
    // Main sequence
    //****************************************
    initial begin
        clk     = 1'b0;
        rst     = 1'b1;
        addr    = 8'h00;
        wdata   = 8'h00;
        w_en    = 1'b0;
        r_en    = 1'b0;
        pins_in = 8'h00;
        repeat (3) @(posedge clk);
        #1;
        rst = 1'b0;
        test_reset_state();
        test_readback();
        test_gpio();
        test_ctc();
        test_pwm();
        $display("STATUS: PASS");
        $finish;
    end

endmodule

`default_nettype wire

// File: vlog.f
source/io_pkg.sv
source/io_regs.sv
source/io_prescaler.sv
source/io_timer.sv
source/io_gpio.sv
source/io_top.sv
tests/io_tb.sv
